//--- src/cachePkg.sv
// Cache geometry and miss sequencer definitions
// Shared by the lookup, storage and miss control blocks

package cachePkg;

    // Byte address width of the processor
    parameter int addrWidth = 32;

    // Bytes packed in one data word
    parameter int wordBytes = 4;

    // Miss sequencer states
    // missIdle       no miss in progress, hits complete here
    // missWriteback  dirty victim words go out to memory
    // missFill       block words come in from memory
    // missDone       one settling cycle before the lookup hits
    typedef enum logic [1:0] {
        missIdle,
        missWriteback,
        missFill,
        missDone
    } missState;

endpackage

//--- src/busPkg.sv
// Memory bus definitions
// Word width and the kind of beat requested on the bus

package busPkg;

    // Every beat moves one full word
    parameter int busWidth = 32;

    // Beat kind, decoded into HRequest and HWrite at the top
    typedef enum logic [1:0] {
        cmdNone,
        cmdRead,
        cmdWrite
    } busCmd;

endpackage

//--- src/cacheWays.sv
// Two-way cache storage
// Tags, valid and dirty bits, block data and one LRU bit per set

module cacheWays #(
    parameter int sets = 2,
    parameter int blockWords = 4,
    localparam int setBits = $clog2(sets),
    localparam int wordBits = $clog2(blockWords),
    localparam int tagBits = cachePkg::addrWidth - 2 - setBits - wordBits
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [setBits-1:0]          SetIndex,
    input  logic [wordBits-1:0]         WordOffset,
    input  logic [wordBits-1:0]         ReadOffset,
    input  logic [wordBits-1:0]         FillWord,
    input  logic                        HitWe,
    input  logic                        HitWay,
    input  logic                        FillWe,
    input  logic                        FillWay,
    input  logic                        LineValidate,
    input  logic                        LruTouch,
    input  logic [busPkg::busWidth-1:0] MergedWord,
    input  logic [busPkg::busWidth-1:0] FillData,
    input  logic [tagBits-1:0]          NewTag,
    output logic                        Way0Valid,
    output logic                        Way1Valid,
    output logic                        Way0Dirty,
    output logic                        Way1Dirty,
    output logic                        LruWay,
    output logic [tagBits-1:0]          Way0Tag,
    output logic [tagBits-1:0]          Way1Tag,
    output logic [busPkg::busWidth-1:0] Way0Word,
    output logic [busPkg::busWidth-1:0] Way1Word
);

    import busPkg::*;

    // Line state, bit 0 is way 0 and bit 1 is way 1
    logic [1:0] validBits [sets];
    logic [1:0] dirtyBits [sets];

    // Least recently used way of each set
    logic lruBits [sets];

    // Tag and block storage indexed by way first
    logic [tagBits-1:0]  tagMem  [2][sets];
    logic [busWidth-1:0] dataMem [2][sets][blockWords];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validBits <= '{default: '0};
            dirtyBits <= '{default: '0};
            lruBits   <= '{default: 1'b0};
        end else begin
            // New line is clean until the first store hits it
            if (LineValidate) begin
                validBits[SetIndex][FillWay] <= 1'b1;
                dirtyBits[SetIndex][FillWay] <= 1'b0;
            end
            if (HitWe) begin
                dirtyBits[SetIndex][HitWay] <= 1'b1;
            end
            // The other way becomes least recently used
            if (LruTouch) begin
                lruBits[SetIndex] <= ~HitWay;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (FillWe) begin
            dataMem[FillWay][SetIndex][FillWord] <= FillData;
        end
        if (HitWe) begin
            dataMem[HitWay][SetIndex][WordOffset] <= MergedWord;
        end
        if (LineValidate) begin
            tagMem[FillWay][SetIndex] <= NewTag;
        end
    end

    // Combinational read of the addressed set
    assign Way0Valid = validBits[SetIndex][0];
    assign Way1Valid = validBits[SetIndex][1];
    assign Way0Dirty = dirtyBits[SetIndex][0];
    assign Way1Dirty = dirtyBits[SetIndex][1];
    assign LruWay    = lruBits[SetIndex];
    assign Way0Tag   = tagMem[0][SetIndex];
    assign Way1Tag   = tagMem[1][SetIndex];
    assign Way0Word  = dataMem[0][SetIndex][ReadOffset];
    assign Way1Word  = dataMem[1][SetIndex][ReadOffset];

endmodule

//--- src/lookupStage.sv
// Address lookup stage
// Tag compare, hit and victim selection, read mux and store byte merge

module lookupStage #(
    parameter int sets = 2,
    parameter int blockWords = 4,
    localparam int setBits = $clog2(sets),
    localparam int wordBits = $clog2(blockWords),
    localparam int tagBits = cachePkg::addrWidth - 2 - setBits - wordBits
) (
    input  logic [cachePkg::addrWidth-1:0] VirtA,
    input  logic [busPkg::busWidth-1:0]    WD,
    input  logic [cachePkg::wordBytes-1:0] ByteMask,
    input  logic                           MemRead,
    input  logic                           MemWrite,
    input  logic                           Busy,
    input  logic                           WaySel,
    input  logic [wordBits-1:0]            WordSel,
    input  logic [tagBits-1:0]             Way0Tag,
    input  logic [tagBits-1:0]             Way1Tag,
    input  logic                           Way0Valid,
    input  logic                           Way1Valid,
    input  logic                           Way0Dirty,
    input  logic                           Way1Dirty,
    input  logic [busPkg::busWidth-1:0]    Way0Word,
    input  logic [busPkg::busWidth-1:0]    Way1Word,
    input  logic                           LruWay,
    output logic [setBits-1:0]             SetIndex,
    output logic [tagBits-1:0]             BlockTag,
    output logic [wordBits-1:0]            WordOffset,
    output logic [wordBits-1:0]            ReadOffset,
    output logic                           Hit,
    output logic                           Active,
    output logic                           HitWay,
    output logic                           HitWe,
    output logic                           LruTouch,
    output logic                           VictimWay,
    output logic                           VictimDirty,
    output logic [tagBits-1:0]             VictimTag,
    output logic [busPkg::busWidth-1:0]    MergedWord,
    output logic [busPkg::busWidth-1:0]    RD
);

    import cachePkg::*;

    logic hit0;
    logic hit1;
    logic readWay;

    // Address fields above the byte offset
    assign WordOffset = VirtA[2 +: wordBits];
    assign SetIndex   = VirtA[2 + wordBits +: setBits];
    assign BlockTag   = VirtA[addrWidth-1 -: tagBits];

    assign Active = MemRead | MemWrite;

    assign hit0   = Way0Valid && (Way0Tag == BlockTag);
    assign hit1   = Way1Valid && (Way1Tag == BlockTag);
    assign Hit    = hit0 | hit1;
    assign HitWay = hit1;

    // Nothing commits while a miss is being serviced
    assign HitWe    = MemWrite && Hit && !Busy;
    assign LruTouch = Active && Hit && !Busy;

    // Replacement follows the LRU bit
    assign VictimWay   = LruWay;
    assign VictimDirty = LruWay ? Way1Dirty : Way0Dirty;
    assign VictimTag   = LruWay ? Way1Tag : Way0Tag;

    // Miss sequencer owns the read path during writeback
    assign readWay    = Busy ? WaySel : HitWay;
    assign ReadOffset = Busy ? WordSel : WordOffset;
    assign RD         = readWay ? Way1Word : Way0Word;

    // Store bytes replace the old ones under the mask
    always_comb begin
        for (int b = 0; b < wordBytes; b++) begin
            MergedWord[8*b +: 8] = ByteMask[b] ? WD[8*b +: 8] : RD[8*b +: 8];
        end
    end

endmodule

//--- src/missControl.sv
// Miss sequencer
// Writes back a dirty victim, fills the block over the bus, holds Stall

module missControl #(
    parameter int sets = 2,
    parameter int blockWords = 4,
    localparam int setBits = $clog2(sets),
    localparam int wordBits = $clog2(blockWords),
    localparam int tagBits = cachePkg::addrWidth - 2 - setBits - wordBits
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           Active,
    input  logic                           Hit,
    input  logic                           VictimWay,
    input  logic                           VictimDirty,
    input  logic [tagBits-1:0]             VictimTag,
    input  logic [tagBits-1:0]             BlockTag,
    input  logic [setBits-1:0]             SetIndex,
    input  logic                           BusReady,
    output cachePkg::missState             State,
    output busPkg::busCmd                  Cmd,
    output logic [cachePkg::addrWidth-1:0] HAddr,
    output logic                           Busy,
    output logic                           Stall,
    output logic                           FillWe,
    output logic                           FillWay,
    output logic                           LineValidate,
    output logic                           WaySel,
    output logic [wordBits-1:0]            WordSel,
    output logic [wordBits-1:0]            FillWord
);

    import cachePkg::*;
    import busPkg::*;

    // Word within the block for the current beat
    logic [wordBits-1:0] beatCount;

    // Way chosen for replacement when the miss began
    logic victimWayQ;

    logic missStart;
    logic lastBeat;
    logic [tagBits-1:0] beatTag;

    assign missStart = (State == missIdle) && Active && !Hit;
    assign lastBeat  = beatCount == wordBits'(blockWords - 1);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            State      <= missIdle;
            beatCount  <= '0;
            victimWayQ <= 1'b0;
        end else begin
            case (State)
                missIdle: begin
                    if (missStart) begin
                        victimWayQ <= VictimWay;
                        beatCount  <= '0;
                        State      <= VictimDirty ? missWriteback : missFill;
                    end
                end
                missWriteback: begin
                    if (BusReady) begin
                        // Counter wraps to zero for the fill
                        beatCount <= beatCount + 1'b1;
                        if (lastBeat) begin
                            State <= missFill;
                        end
                    end
                end
                missFill: begin
                    if (BusReady) begin
                        beatCount <= beatCount + 1'b1;
                        if (lastBeat) begin
                            State <= missDone;
                        end
                    end
                end
                missDone: begin
                    State <= missIdle;
                end
                default: begin
                    State <= missIdle;
                end
            endcase
        end
    end

    always_comb begin
        case (State)
            missWriteback: Cmd = cmdWrite;
            missFill:      Cmd = cmdRead;
            default:       Cmd = cmdNone;
        endcase
    end

    // Writeback goes to the victim's home, fill to the requested block
    assign beatTag = (State == missWriteback) ? VictimTag : BlockTag;
    assign HAddr   = {beatTag, SetIndex, beatCount, 2'b00};

    // Fill data lands at the clock edge that ends the beat
    assign FillWe       = (State == missFill) && BusReady;
    assign FillWay      = victimWayQ;
    assign FillWord     = beatCount;
    assign LineValidate = FillWe && lastBeat;

    // Victim words stream out through the lookup read path
    assign WaySel  = victimWayQ;
    assign WordSel = beatCount;

    assign Busy  = State != missIdle;
    assign Stall = missStart || Busy;

endmodule

//--- src/dataCacheTop.sv
// Writeback data cache top
// Two-way set-associative cache between the processor and a word-wide bus

module dataCacheTop #(
    parameter int sets = 2,
    parameter int blockWords = 4,
    localparam int setBits = $clog2(sets),
    localparam int wordBits = $clog2(blockWords),
    localparam int tagBits = cachePkg::addrWidth - 2 - setBits - wordBits
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           MemRead,
    input  logic                           MemWrite,
    input  logic [cachePkg::addrWidth-1:0] VirtA,
    input  logic [busPkg::busWidth-1:0]    WD,
    input  logic [cachePkg::wordBytes-1:0] ByteMask,
    input  logic [busPkg::busWidth-1:0]    HRData,
    input  logic                           BusReady,
    output logic [busPkg::busWidth-1:0]    RD,
    output logic                           Stall,
    output logic [cachePkg::addrWidth-1:0] HAddr,
    output logic [busPkg::busWidth-1:0]    HWData,
    output logic                           HWrite,
    output logic                           HRequest
);

    import busPkg::*;

    // Storage to lookup
    logic way0Valid, way1Valid, way0Dirty, way1Dirty, lruWay;
    logic [tagBits-1:0]  way0Tag, way1Tag;
    logic [busWidth-1:0] way0Word, way1Word;

    // Lookup to storage and sequencer
    logic [setBits-1:0]  setIndex;
    logic [tagBits-1:0]  blockTag, victimTag;
    logic [wordBits-1:0] wordOffset, readOffset;
    logic hit, active, hitWay, hitWe, lruTouch, victimWay, victimDirty;
    logic [busWidth-1:0] mergedWord;

    // Sequencer to storage and lookup
    busCmd cmd;
    logic busy, fillWe, fillWay, lineValidate, waySel;
    logic [wordBits-1:0] wordSel, fillWord;

    cacheWays #(.sets(sets), .blockWords(blockWords)) u_cacheWays (
        .clk(clk), .rstN(rstN), .SetIndex(setIndex), .WordOffset(wordOffset),
        .ReadOffset(readOffset), .FillWord(fillWord), .HitWe(hitWe), .HitWay(hitWay),
        .FillWe(fillWe), .FillWay(fillWay), .LineValidate(lineValidate),
        .LruTouch(lruTouch), .MergedWord(mergedWord), .FillData(HRData),
        .NewTag(blockTag), .Way0Valid(way0Valid), .Way1Valid(way1Valid),
        .Way0Dirty(way0Dirty), .Way1Dirty(way1Dirty), .LruWay(lruWay),
        .Way0Tag(way0Tag), .Way1Tag(way1Tag), .Way0Word(way0Word), .Way1Word(way1Word)
    );

    lookupStage #(.sets(sets), .blockWords(blockWords)) u_lookupStage (
        .VirtA(VirtA), .WD(WD), .ByteMask(ByteMask), .MemRead(MemRead),
        .MemWrite(MemWrite), .Busy(busy), .WaySel(waySel), .WordSel(wordSel),
        .Way0Tag(way0Tag), .Way1Tag(way1Tag), .Way0Valid(way0Valid),
        .Way1Valid(way1Valid), .Way0Dirty(way0Dirty), .Way1Dirty(way1Dirty),
        .Way0Word(way0Word), .Way1Word(way1Word), .LruWay(lruWay),
        .SetIndex(setIndex), .BlockTag(blockTag), .WordOffset(wordOffset),
        .ReadOffset(readOffset), .Hit(hit), .Active(active), .HitWay(hitWay),
        .HitWe(hitWe), .LruTouch(lruTouch), .VictimWay(victimWay),
        .VictimDirty(victimDirty), .VictimTag(victimTag), .MergedWord(mergedWord),
        .RD(RD)
    );

    // Sequencer state is observed by the bound bus checks
    missControl #(.sets(sets), .blockWords(blockWords)) u_missControl (
        .clk(clk), .rstN(rstN), .Active(active), .Hit(hit), .VictimWay(victimWay),
        .VictimDirty(victimDirty), .VictimTag(victimTag), .BlockTag(blockTag),
        .SetIndex(setIndex), .BusReady(BusReady), .State(), .Cmd(cmd), .HAddr(HAddr),
        .Busy(busy), .Stall(Stall), .FillWe(fillWe), .FillWay(fillWay),
        .LineValidate(lineValidate), .WaySel(waySel), .WordSel(wordSel),
        .FillWord(fillWord)
    );

    // Victim word on the read path during writeback
    assign HWData = RD;

    assign HWrite   = cmd == cmdWrite;
    assign HRequest = cmd != cmdNone;

endmodule

//--- tests/dataCache_props.sv
// Bus and stall checks for the miss sequencer
// Bound into missControl by the testbench

module dataCacheProps (
    input logic                           clk,
    input logic                           rstN,
    input logic                           BusReady,
    input logic                           Stall,
    input cachePkg::missState             State,
    input busPkg::busCmd                  Cmd,
    input logic [cachePkg::addrWidth-1:0] HAddr
);

    import cachePkg::*;
    import busPkg::*;

    // A pending beat keeps its kind and address until BusReady
    beatHold: assert property (@(posedge clk) disable iff (!rstN)
        (Cmd != cmdNone && !BusReady) |=> ($stable(Cmd) && $stable(HAddr)))
        else $error("bus beat changed while BusReady was low");

    // A miss keeps Stall up until its done cycle
    stallWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
        (Stall && State != missDone) |=> Stall)
        else $error("Stall dropped before the miss sequencer finished");

    // Bus stays quiet between misses
    idleQuiet: assert property (@(posedge clk) disable iff (!rstN)
        (State == missIdle && !Stall) |=> (Cmd == cmdNone))
        else $error("bus request issued without a miss");

endmodule

//--- tests/dataCacheTb.sv
// Data cache testbench
// Drives loads and stores, models main memory, checks reads against a shadow copy

module dataCacheTb;

    import cachePkg::*;
    import busPkg::*;

    localparam int blockWords = 4;
    localparam int requestCount = 378;
    localparam int timeoutCycles = requestCount * 2 * blockWords * 4 + 200;

    logic clk = 1'b0;
    logic rstN, MemRead, MemWrite;
    logic [addrWidth-1:0] VirtA;
    logic [busWidth-1:0] WD;
    logic [wordBytes-1:0] ByteMask;
    logic [busWidth-1:0] HRData = '0;
    logic BusReady = 1'b0;
    logic [busWidth-1:0] RD, HWData;
    logic [addrWidth-1:0] HAddr;
    logic Stall, HWrite, HRequest;

    // Responder memory and the architectural copy
    logic [busWidth-1:0] mainMem [64];
    logic [busWidth-1:0] shadowMem [64];

    // Completed beats of the latest access
    logic [addrWidth-1:0] beatAddr [$];
    logic beatWrite [$];
    logic [busWidth-1:0] beatData [$];

    int readyDelay = 0;
    int checkCount = 0;
    int valueErrors = 0;
    int otherErrors = 0;
    string curTest = "reset";
    logic [busWidth-1:0] expectedWord;

    dataCacheTop #(.sets(2), .blockWords(blockWords)) u_dataCacheTop (
        .clk(clk), .rstN(rstN), .MemRead(MemRead), .MemWrite(MemWrite), .VirtA(VirtA),
        .WD(WD), .ByteMask(ByteMask), .HRData(HRData), .BusReady(BusReady), .RD(RD),
        .Stall(Stall), .HAddr(HAddr), .HWData(HWData), .HWrite(HWrite), .HRequest(HRequest)
    );

    bind missControl dataCacheProps u_dataCacheProps (
        .clk(clk), .rstN(rstN), .BusReady(BusReady), .Stall(Stall), .State(State),
        .Cmd(Cmd), .HAddr(HAddr)
    );

    always #10 clk = ~clk;

    function automatic logic [busWidth-1:0] refRead(input logic [addrWidth-1:0] addr);
        return shadowMem[addr[7:2]];
    endfunction

    // Bytes with a set mask bit come from the store data
    function automatic logic [busWidth-1:0] mergeBytes(input logic [busWidth-1:0] old,
            input logic [busWidth-1:0] data, input logic [wordBytes-1:0] mask);
        logic [busWidth-1:0] word;
        word = old;
        for (int b = 0; b < wordBytes; b++) begin
            if (mask[b]) word[8*b +: 8] = data[8*b +: 8];
        end
        return word;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        valueErrors++;
        $display("error %s: expected %h, actual %h", name, expected, actual);
    endtask

    task automatic reportFailure(input string what);
        otherErrors++;
        $display("%s: %s", curTest, what);
    endtask

    task automatic startTest(input string name);
        curTest <= name;
        @(posedge clk);
    endtask

    // One processor request, held until a cycle without Stall
    task automatic cacheAccess(input logic isWrite, input logic [31:0] addr,
            input logic [31:0] data, input logic [3:0] mask, output int stalls);
        stalls = 0;
        beatAddr.delete();
        beatWrite.delete();
        beatData.delete();
        MemRead  <= !isWrite;
        MemWrite <= isWrite;
        VirtA    <= addr;
        WD       <= data;
        ByteMask <= mask;
        @(posedge clk);
        while (Stall) begin
            stalls++;
            @(posedge clk);
        end
        if (isWrite) shadowMem[addr[7:2]] = mergeBytes(shadowMem[addr[7:2]], data, mask);
        MemRead  <= 1'b0;
        MemWrite <= 1'b0;
    endtask

    // Logged beats against one block, words in ascending order
    task automatic checkBeats(input logic [31:0] base, input int first, input logic isWrite);
        for (int i = 0; i < blockWords; i++) begin
            checkCount++;
            if (beatAddr[first + i] !== base + 4 * i) begin
                reportMismatch(curTest, base + 4 * i, beatAddr[first + i]);
            end
            if (beatWrite[first + i] !== isWrite) reportFailure("bus beat has the wrong direction");
            if (isWrite && beatData[first + i] !== shadowMem[(base >> 2) + i]) begin
                reportMismatch(curTest, shadowMem[(base >> 2) + i], beatData[first + i]);
            end
        end
    endtask

    // Main memory answers each beat after a random wait
    always @(posedge clk) begin
        if (!rstN) begin
            BusReady <= 1'b0;
        end else if (BusReady) begin
            if (HWrite) mainMem[HAddr[7:2]] <= HWData;
            beatAddr.push_back(HAddr);
            beatWrite.push_back(HWrite);
            beatData.push_back(HWrite ? HWData : HRData);
            BusReady   <= 1'b0;
            readyDelay <= $urandom_range(0, 3);
        end else if (HRequest) begin
            if (readyDelay == 0) begin
                BusReady <= 1'b1;
                HRData   <= mainMem[HAddr[7:2]];
            end else begin
                readyDelay <= readyDelay - 1;
            end
        end
    end

    // Every completed read against the reference
    always @(posedge clk) begin
        if (rstN && MemRead && !Stall) begin
            expectedWord = refRead(VirtA);
            checkCount++;
            if (RD !== expectedWord) reportMismatch(curTest, expectedWord, RD);
        end
    end

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", timeoutCycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int stalls;
        logic [addrWidth-1:0] addr;
        logic isWrite;
        void'($urandom(32'h5da56589));
        rstN     = 1'b0;
        MemRead  = 1'b0;
        MemWrite = 1'b0;
        VirtA    = '0;
        WD       = '0;
        ByteMask = '0;
        for (int i = 0; i < 64; i++) begin
            mainMem[i]   = 32'h5A00_0000 ^ (i * 32'h0001_0203);
            shadowMem[i] = mainMem[i];
        end
        repeat (10) @(posedge clk);
        rstN <= 1'b1;

        startTest("reset");
        if (Stall !== 1'b0 || HRequest !== 1'b0) reportFailure("Stall or HRequest high after reset");
        cacheAccess(1'b0, 32'h10, '0, '0, stalls);
        if (stalls == 0) reportFailure("first read after reset did not miss");

        startTest("read miss then hit");
        cacheAccess(1'b0, 32'h04, '0, '0, stalls);
        if (beatAddr.size() != blockWords) reportMismatch(curTest, blockWords, beatAddr.size());
        checkBeats(32'h00, 0, 1'b0);
        cacheAccess(1'b0, 32'h08, '0, '0, stalls);
        if (stalls != 0) reportFailure("second read to the same block stalled");

        startTest("byte store hit");
        cacheAccess(1'b1, 32'h08, 32'h1122_3344, 4'b0101, stalls);
        if (stalls != 0) reportFailure("store to a cached word stalled");
        cacheAccess(1'b0, 32'h08, '0, '0, stalls);

        // Blocks 0x00, 0x20 and 0x40 share set 0
        startTest("dirty eviction");
        cacheAccess(1'b1, 32'h00, 32'hA1B2_C3D4, 4'b1111, stalls);
        cacheAccess(1'b0, 32'h20, '0, '0, stalls);
        cacheAccess(1'b0, 32'h40, '0, '0, stalls);
        if (beatAddr.size() != 2 * blockWords) begin
            reportMismatch(curTest, 2 * blockWords, beatAddr.size());
        end
        checkBeats(32'h00, 0, 1'b1);
        checkBeats(32'h40, blockWords, 1'b0);
        for (int i = 0; i < blockWords; i++) begin
            if (mainMem[i] !== shadowMem[i]) reportMismatch(curTest, shadowMem[i], mainMem[i]);
        end

        // Set 1 with A at 0x10, B at 0x30, C at 0x50
        startTest("lru choice");
        cacheAccess(1'b0, 32'h10, '0, '0, stalls);
        cacheAccess(1'b0, 32'h30, '0, '0, stalls);
        cacheAccess(1'b0, 32'h10, '0, '0, stalls);
        cacheAccess(1'b0, 32'h50, '0, '0, stalls);
        cacheAccess(1'b0, 32'h10, '0, '0, stalls);
        if (stalls != 0) reportFailure("read of A missed although B was least recently used");
        cacheAccess(1'b0, 32'h30, '0, '0, stalls);
        if (beatAddr.size() != blockWords) reportMismatch(curTest, blockWords, beatAddr.size());
        checkBeats(32'h30, 0, 1'b0);

        startTest("random mix");
        for (int n = 0; n < 300; n++) begin
            addr    = $urandom_range(0, 63) << 2;
            isWrite = $urandom_range(0, 1);
            cacheAccess(isWrite, addr, $urandom, $urandom_range(0, 15), stalls);
        end

        startTest("read back");
        for (int i = 0; i < 64; i++) begin
            cacheAccess(1'b0, i * 4, '0, '0, stalls);
        end
        @(posedge clk);

        $display("checks %0d, value errors %0d, other errors %0d",
                 checkCount, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- dataCacheTop.f
src/cachePkg.sv
src/busPkg.sv
src/cacheWays.sv
src/lookupStage.sv
src/missControl.sv
src/dataCacheTop.sv
tests/dataCache_props.sv
tests/dataCacheTb.sv
